//--- sources.f
design/spm_pkg.sv
design/lzc.sv
design/rr_arbiter.sv
design/req_capture.sv
design/spm_ctrl.sv
design/spm_bank.sv
design/rsp_router.sv
design/spm_top.sv
test/tb_spm.sv

//--- Bender.yml
package:
  name: spm

sources:
  - design/spm_pkg.sv
  - design/lzc.sv
  - design/rr_arbiter.sv
  - design/req_capture.sv
  - design/spm_ctrl.sv
  - design/spm_bank.sv
  - design/rsp_router.sv
  - design/spm_top.sv
  - target: test
    files:
      - test/tb_spm.sv

//--- test/tb_spm.sv
module tb_spm;

    import spm_pkg::*;

    logic                            clk_i;
    logic                            rst_ni;
    logic                            flush;
    logic [NUM_PORTS-1:0]            req;
    spm_req_t [NUM_PORTS-1:0]        req_data;
    logic [NUM_PORTS-1:0]            gnt;
    logic [NUM_PORTS-1:0]            rsp_vld;
    spm_rsp_t                        rsp;

    integer seed = 32'hf2c3;
    string  test_name = "reset";

    // reference state that the compare process advances once per cycle
    logic [DATA_W-1:0] ref_mem [2**ADDR_W];
    int unsigned       ref_ptr = 0;
    int unsigned       phase = 0;
    int unsigned       cap_port_m = 0;
    spm_req_t          cap_req_m;
    logic [DATA_W-1:0] exp_rdata;

    spm_top dut0 (
        .clk_i      ( clk_i    ),
        .rst_ni     ( rst_ni   ),
        .flush_i    ( flush    ),
        .req_i      ( req      ),
        .req_data_i ( req_data ),
        .gnt_o      ( gnt      ),
        .rsp_vld_o  ( rsp_vld  ),
        .rsp_o      ( rsp      )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // picks the nearest requester after the last served one, so the last served port comes last
    function automatic int unsigned rr_winner(input int unsigned last,
                                              input logic [NUM_PORTS-1:0] reqs);
        int unsigned cand;
        rr_winner = last;
        for (int k = NUM_PORTS; k >= 1; k--) begin
            cand = (last + k) % NUM_PORTS;
            if (reqs[cand]) begin
                rr_winner = cand;
            end
        end
    endfunction

    // every word gets a different value so a wrong address shows up in a read
    function automatic logic [DATA_W-1:0] fill_word(input int unsigned addr);
        fill_word = 32'h9e37_0000 ^ (addr * 32'h0101_0107);
    endfunction

    // the reference runs a grant, an access and a response cycle per request
    always @(negedge clk_i) begin : p_compare
        logic [NUM_PORTS-1:0] exp_gnt;
        logic [NUM_PORTS-1:0] exp_rsp;
        int unsigned          win;
        if (rst_ni) begin
            exp_gnt = '0;
            exp_rsp = '0;
            win = 0;
            if (phase == 0 && !flush && (|req)) begin
                win = rr_winner(ref_ptr, req);
                exp_gnt[win] = 1'b1;
            end
            // a flush in the response cycle swallows the pulse
            if (phase == 2 && !flush) begin
                exp_rsp[cap_port_m] = 1'b1;
            end
            check("grant", 32'(exp_gnt), 32'(gnt));
            check("response valid", 32'(exp_rsp), 32'(rsp_vld));
            if (|exp_rsp) begin
                check("write flag", 32'(cap_req_m.we), 32'(rsp.was_write));
                if (!cap_req_m.we) begin
                    check("read data", exp_rdata, rsp.rdata);
                end
            end
            // the bank access happens even when a flush follows the grant
            if (phase == 1) begin
                if (cap_req_m.we) begin
                    for (int b = 0; b < BE_W; b++) begin
                        if (cap_req_m.be[b]) begin
                            ref_mem[cap_req_m.addr][8*b +: 8] = cap_req_m.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    exp_rdata = ref_mem[cap_req_m.addr];
                end
            end
            if (flush) begin
                phase = 0;
                ref_ptr = 0;
            end else if (phase == 0) begin
                if (|exp_gnt) begin
                    phase = 1;
                    ref_ptr = win;
                    cap_port_m = win;
                    cap_req_m = req_data[win];
                end
            end else begin
                phase = (phase == 1) ? 2 : 0;
            end
        end
    end

    task automatic set_req(input int unsigned port, input logic we,
                           input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                           input logic [DATA_W-1:0] wdata);
        req_data[port].we = we;
        req_data[port].addr = addr;
        req_data[port].be = be;
        req_data[port].wdata = wdata;
        req[port] = 1'b1;
    endtask

    task automatic set_random_req(input int unsigned port);
        logic [31:0] r;
        r = $random(seed);
        set_req(port, r[0], r[ADDR_W:1], r[ADDR_W+BE_W:ADDR_W+1], $random(seed));
    endtask

    // cycles counts the falling edges up to and including the grant
    task automatic wait_grant(output int unsigned port, output int unsigned cycles);
        bit got;
        got = 1'b0;
        port = 0;
        cycles = 0;
        for (int i = 0; i < 20 && !got; i++) begin
            @(negedge clk_i);
            cycles++;
            for (int k = 0; k < NUM_PORTS; k++) begin
                if (gnt[k]) begin
                    port = k;
                    got = 1'b1;
                end
            end
        end
        if (!got) begin
            $display("no grant arrived within 20 cycles during %s", test_name);
            abort_run();
        end
    endtask

    task automatic wait_rsp(input int unsigned port);
        bit got;
        got = 1'b0;
        for (int i = 0; i < 20 && !got; i++) begin
            @(negedge clk_i);
            got = rsp_vld[port];
        end
        if (!got) begin
            $display("port %0d got no response within 20 cycles during %s", port, test_name);
            abort_run();
        end
    endtask

    task automatic single_access(input int unsigned port, input logic we,
                                 input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                                 input logic [DATA_W-1:0] wdata);
        int unsigned gp;
        int unsigned cyc;
        @(posedge clk_i);
        #2;
        set_req(port, we, addr, be, wdata);
        wait_grant(gp, cyc);
        check("granted port", port, gp);
        @(posedge clk_i);
        #2;
        req[port] = 1'b0;
        wait_rsp(port);
    endtask

    // leaves flush low again in the cycle after the pulse
    task automatic pulse_flush();
        @(posedge clk_i);
        #2;
        flush = 1'b1;
        @(posedge clk_i);
        #2;
        flush = 1'b0;
    endtask

    initial begin : p_main
        int unsigned       gp;
        int unsigned       cyc;
        int unsigned       issued;
        logic [31:0]       r;
        bit                have_gnt;
        logic [DATA_W-1:0] merged;
        rst_ni = 1'b0;
        flush = 1'b0;
        req = '0;
        req_data = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        test_name = "single port";
        single_access(2, 1'b1, 6'h15, 4'hf, 32'hcafe_f00d);
        single_access(2, 1'b0, 6'h15, 4'h0, 32'h0);
        check("read back", 32'hcafe_f00d, rsp.rdata);

        // known contents everywhere so later reads never see an unwritten word
        test_name = "fill";
        for (int a = 0; a < 2**ADDR_W; a++) begin
            single_access(a % NUM_PORTS, 1'b1, ADDR_W'(a), 4'hf, fill_word(a));
        end

        test_name = "byte enables";
        single_access(0, 1'b1, 6'h03, 4'b0001, 32'h1122_3344);
        single_access(1, 1'b1, 6'h03, 4'b0110, 32'haabb_ccdd);
        single_access(3, 1'b1, 6'h20, 4'b1000, 32'h7700_0000);
        single_access(2, 1'b1, 6'h20, 4'b0000, 32'hffff_ffff);
        single_access(1, 1'b1, 6'h3f, 4'b1010, 32'h5566_7788);
        single_access(0, 1'b0, 6'h03, 4'h0, 32'h0);
        // top byte keeps the fill value, the lower three come from the two partial writes
        merged = fill_word(3);
        merged[23:0] = 24'hbb_cc44;
        check("byte merge", merged, rsp.rdata);
        single_access(3, 1'b0, 6'h20, 4'h0, 32'h0);
        single_access(2, 1'b0, 6'h3f, 4'h0, 32'h0);

        // all four keep requesting and a granted port presents a fresh request
        test_name = "round robin";
        pulse_flush();
        for (int p = 0; p < NUM_PORTS; p++) begin
            set_random_req(p);
        end
        for (int n = 0; n < 12; n++) begin
            wait_grant(gp, cyc);
            check("grant order", (n + 1) % NUM_PORTS, gp);
            @(posedge clk_i);
            #2;
            if (n < 11) begin
                set_random_req(gp);
            end else begin
                req = '0;
            end
        end
        wait_rsp(gp);

        test_name = "lookahead";
        pulse_flush();
        set_random_req(0);
        set_random_req(3);
        for (int n = 0; n < 8; n++) begin
            wait_grant(gp, cyc);
            check("alternating grant", (n % 2 == 0) ? 3 : 0, gp);
            if (n > 0) begin
                check("grant spacing", 3, cyc);
            end
            @(posedge clk_i);
            #2;
            if (n < 7) begin
                set_random_req(gp);
            end else begin
                req = '0;
            end
        end
        wait_rsp(gp);

        test_name = "random traffic";
        issued = 0;
        have_gnt = 1'b0;
        while (issued < 200 || (|req)) begin
            @(posedge clk_i);
            #2;
            if (have_gnt) begin
                req[gp] = 1'b0;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                r = $random(seed);
                if (!req[p] && issued < 200 && r[0]) begin
                    set_random_req(p);
                    issued++;
                end
            end
            // an idle bus would only waste cycles
            if (!(|req) && issued < 200) begin
                r = $random(seed);
                set_random_req(r[1:0]);
                issued++;
            end
            have_gnt = |req;
            if (have_gnt) begin
                wait_grant(gp, cyc);
            end
        end
        wait_rsp(gp);

        // port 2 writes and the flush hits its access cycle, then ports 0 and 1 compete
        test_name = "flush";
        @(posedge clk_i);
        #2;
        set_req(2, 1'b1, 6'h2a, 4'hf, 32'h0bad_cafe);
        wait_grant(gp, cyc);
        check("granted port", 2, gp);
        @(posedge clk_i);
        #2;
        flush = 1'b1;
        req[2] = 1'b0;
        set_req(0, 1'b0, 6'h01, 4'h0, 32'h0);
        set_req(1, 1'b0, 6'h2a, 4'h0, 32'h0);
        @(posedge clk_i);
        #2;
        flush = 1'b0;
        wait_grant(gp, cyc);
        check("grant after flush", 1, gp);
        @(posedge clk_i);
        #2;
        req[1] = 1'b0;
        wait_rsp(1);
        check("write kept after flush", 32'h0bad_cafe, rsp.rdata);
        wait_grant(gp, cyc);
        check("granted port", 0, gp);
        @(posedge clk_i);
        #2;
        req[0] = 1'b0;
        wait_rsp(0);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- design/spm_top.sv
module spm_top (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      flush_i,
    input  logic [spm_pkg::NUM_PORTS-1:0]             req_i,
    input  spm_pkg::spm_req_t [spm_pkg::NUM_PORTS-1:0] req_data_i,
    output logic [spm_pkg::NUM_PORTS-1:0]             gnt_o,
    output logic [spm_pkg::NUM_PORTS-1:0]             rsp_vld_o,
    output spm_pkg::spm_rsp_t                         rsp_o
);

    import spm_pkg::*;

    logic              arb_en;
    logic              arb_vld;
    logic [PORT_W-1:0] arb_idx;
    logic              cap_en;
    logic              bank_en;
    logic              rsp_en;
    spm_req_t          cap_req;
    logic [PORT_W-1:0] cap_port;
    logic [DATA_W-1:0] bank_rdata;

    // the arbiter acks go straight out as grant pulses
    rr_arbiter #(
        .NUM_REQ ( NUM_PORTS )
    ) i_arbiter (
        .clk_i   ( clk_i   ),
        .rst_ni  ( rst_ni  ),
        .flush_i ( flush_i ),
        .en_i    ( arb_en  ),
        .req_i   ( req_i   ),
        .ack_o   ( gnt_o   ),
        .vld_o   ( arb_vld ),
        .idx_o   ( arb_idx )
    );

    spm_ctrl i_ctrl (
        .clk_i     ( clk_i   ),
        .rst_ni    ( rst_ni  ),
        .flush_i   ( flush_i ),
        .any_req_i ( arb_vld ),
        .arb_en_o  ( arb_en  ),
        .cap_en_o  ( cap_en  ),
        .bank_en_o ( bank_en ),
        .rsp_en_o  ( rsp_en  )
    );

    req_capture i_capture (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .cap_en_i   ( cap_en     ),
        .sel_i      ( arb_idx    ),
        .req_data_i ( req_data_i ),
        .req_o      ( cap_req    ),
        .port_o     ( cap_port   )
    );

    spm_bank i_bank (
        .clk_i   ( clk_i      ),
        .rst_ni  ( rst_ni     ),
        .en_i    ( bank_en    ),
        .req_i   ( cap_req    ),
        .rdata_o ( bank_rdata )
    );

    // response goes back to whichever port was captured
    rsp_router i_router (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .flush_i   ( flush_i    ),
        .en_i      ( rsp_en     ),
        .port_i    ( cap_port   ),
        .we_i      ( cap_req.we ),
        .rdata_i   ( bank_rdata ),
        .rsp_vld_o ( rsp_vld_o  ),
        .rsp_o     ( rsp_o      )
    );

endmodule

//--- design/rsp_router.sv
module rsp_router (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  logic                          en_i,
    input  logic [spm_pkg::PORT_W-1:0]    port_i,
    input  logic                          we_i,
    input  logic [spm_pkg::DATA_W-1:0]    rdata_i,
    output logic [spm_pkg::NUM_PORTS-1:0] rsp_vld_o,
    output spm_pkg::spm_rsp_t             rsp_o
);

    import spm_pkg::*;

    // port select decoded a cycle ahead of the response
    logic [NUM_PORTS-1:0] port_oh_q;
    logic                 was_write_q;

    // the captured port and write flag hold still from the access cycle on,
    // so registering them here keeps the decoder off the response path
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_decode
        if (!rst_ni) begin
            port_oh_q   <= '0;
            was_write_q <= 1'b0;
        end else begin
            port_oh_q   <= NUM_PORTS'(1) << port_i;
            was_write_q <= we_i;
        end
    end

    // only the winning port sees the pulse, and a flush swallows it
    assign rsp_vld_o = (en_i && !flush_i) ? port_oh_q : '0;

    // the bank already holds the read word in its output register
    assign rsp_o.rdata     = rdata_i;
    assign rsp_o.was_write = was_write_q;

    // a response never goes to more than one port
    rsp_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(rsp_vld_o))
        else $error("response pulse on more than one port");

    // each access answers once, a response is a single cycle pulse
    rsp_is_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|rsp_vld_o) |=> !(|rsp_vld_o))
        else $error("response held for more than one cycle");

endmodule

//--- design/spm_bank.sv
module spm_bank (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       en_i,
    input  spm_pkg::spm_req_t          req_i,
    output logic [spm_pkg::DATA_W-1:0] rdata_o
);

    import spm_pkg::*;

    // 64 words of storage, contents are undefined until written
    logic [DATA_W-1:0] mem_q [2**ADDR_W];

    // only the enabled byte lanes of the addressed word change
    always_ff @(posedge clk_i) begin : p_write
        if (en_i && req_i.we) begin
            for (int unsigned b = 0; b < BE_W; b++) begin
                if (req_i.be[b]) begin
                    mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read port is registered, data shows up the cycle after the access
    // and is held until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (en_i && !req_i.we) begin
            rdata_o <= mem_q[req_i.addr];
        end
    end

endmodule

//--- design/spm_ctrl.sv
module spm_ctrl (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    // arbiter valid, high when a grant goes out this cycle
    input  logic any_req_i,
    output logic arb_en_o,
    output logic cap_en_o,
    output logic bank_en_o,
    output logic rsp_en_o
);

    import spm_pkg::*;

    ctrl_state_e state_d;
    ctrl_state_e state_q;

    // one access takes exactly three cycles from grant to response
    always_comb begin : p_next
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (any_req_i) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                state_d = RESPOND;
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
        // a flush abandons whatever is in flight
        if (flush_i) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the arbiter is held off during a flush so no grant is lost
    assign arb_en_o  = (state_q == IDLE) && !flush_i;
    // the winner is captured in the same cycle its grant goes out
    assign cap_en_o  = (state_q == IDLE) && any_req_i;
    assign bank_en_o = (state_q == ACCESS);
    assign rsp_en_o  = (state_q == RESPOND);

    // capture must never overwrite a request that is still in flight
    cap_only_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cap_en_o |-> (state_q == IDLE))
        else $error("capture raised outside IDLE");

    // every captured request reaches the bank in the next cycle
    cap_then_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cap_en_o |=> bank_en_o)
        else $error("captured request did not reach the bank");

    // the bank is single ported, back to back accesses would mean overlap
    bank_not_back_to_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bank_en_o |=> !bank_en_o)
        else $error("bank enabled in two consecutive cycles");

endmodule

//--- design/req_capture.sv
module req_capture (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      cap_en_i,
    input  logic [spm_pkg::PORT_W-1:0]                sel_i,
    input  spm_pkg::spm_req_t [spm_pkg::NUM_PORTS-1:0] req_data_i,
    output spm_pkg::spm_req_t                         req_o,
    output logic [spm_pkg::PORT_W-1:0]                port_o
);

    // the winner index steers the response later, so it comes out of reset clean
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_port
        if (!rst_ni) begin
            port_o <= '0;
        end else if (cap_en_i) begin
            port_o <= sel_i;
        end
    end

    // the requester may change its payload right after the grant,
    // so the bank works only from this copy
    always_ff @(posedge clk_i) begin : p_payload
        if (cap_en_i) begin
            req_o <= req_data_i[sel_i];
        end
    end

endmodule

//--- design/rr_arbiter.sv
module rr_arbiter #(
    parameter int unsigned NUM_REQ = spm_pkg::NUM_PORTS
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // clears the last-served pointer back to 0
    input  logic                       flush_i,
    input  logic                       en_i,
    input  logic [NUM_REQ-1:0]         req_i,
    output logic [NUM_REQ-1:0]         ack_o,
    output logic                       vld_o,
    output logic [$clog2(NUM_REQ)-1:0] idx_o
);

    // index of the port that won the last granted arbitration
    logic [$clog2(NUM_REQ)-1:0] ptr_q;

    // requests strictly above the pointer get served first
    logic [NUM_REQ-1:0]         upper_req;
    // requests at or below the pointer are the wrap-around candidates
    logic [NUM_REQ-1:0]         lower_req;
    logic [$clog2(NUM_REQ)-1:0] upper_idx;
    logic [$clog2(NUM_REQ)-1:0] lower_idx;
    logic                       upper_empty;
    logic                       lower_empty;

    // split the request vector around the last-served index
    for (genvar k = 0; k < NUM_REQ; k++) begin : g_mask
        assign upper_req[k] = req_i[k] & (k > ptr_q);
        assign lower_req[k] = req_i[k] & (k <= ptr_q);
    end

    // lookahead means jumping straight to the next pending port
    lzc #(
        .WIDTH ( NUM_REQ )
    ) i_upper_ff1 (
        .in_i    ( upper_req   ),
        .cnt_o   ( upper_idx   ),
        .empty_o ( upper_empty )
    );

    lzc #(
        .WIDTH ( NUM_REQ )
    ) i_lower_ff1 (
        .in_i    ( lower_req   ),
        .cnt_o   ( lower_idx   ),
        .empty_o ( lower_empty )
    );

    // the two halves together cover every request, so both empty means none
    assign vld_o = en_i & ~(upper_empty & lower_empty);

    // wrap to the lower half only when nothing above the pointer is waiting
    assign idx_o = upper_empty ? lower_idx : upper_idx;

    for (genvar k = 0; k < NUM_REQ; k++) begin : g_ack
        assign ack_o[k] = vld_o & (idx_o == k);
    end

    // a port just served drops behind all others that are waiting,
    // which is what keeps any request from starving
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (flush_i) begin
            ptr_q <= '0;
        end else if (vld_o) begin
            ptr_q <= idx_o;
        end
    end

    // the granted port is exactly the one that idx_o names
    ack_matches_idx: assert property (@(posedge clk_i) disable iff (!rst_ni)
        vld_o |-> ($onehot(ack_o) && ack_o[idx_o]))
        else $error("ack_o is not the one-hot decode of idx_o");

    // with the controller busy no port may see a grant
    no_ack_without_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !en_i |-> (ack_o == '0))
        else $error("ack_o raised while the arbiter is disabled");

    // the controller counts on vld_o for exactly the cycles a grant goes out
    vld_iff_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        vld_o == (|ack_o))
        else $error("vld_o and ack_o disagree");

endmodule

//--- design/lzc.sv
module lzc #(
    parameter int unsigned WIDTH = 4
) (
    input  logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    output logic                     empty_o
);

    // the tree is padded up to a power of two leaves
    localparam int unsigned LEVELS = $clog2(WIDTH);
    localparam int unsigned NODES = 2 ** (LEVELS + 1) - 1;

    // nodes are stored heap style, node n has children 2n+1 and 2n+2
    logic [NODES-1:0]  node_vld;
    logic [LEVELS-1:0] node_idx [NODES];

    // leaves sit at the deepest level, padding leaves never see a set bit
    for (genvar p = 0; p < 2 ** LEVELS; p++) begin : g_leaf
        localparam int unsigned N = 2 ** LEVELS - 1 + p;
        if (p < WIDTH) begin : g_in
            assign node_vld[N] = in_i[p];
        end else begin : g_pad
            assign node_vld[N] = 1'b0;
        end
        assign node_idx[N] = LEVELS'(p);
    end

    // each inner node prefers its left child, which covers the lower indices
    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        for (genvar p = 0; p < 2 ** l; p++) begin : g_node
            localparam int unsigned N = 2 ** l - 1 + p;
            assign node_vld[N] = node_vld[2*N+1] | node_vld[2*N+2];
            assign node_idx[N] = node_vld[2*N+1] ? node_idx[2*N+1] : node_idx[2*N+2];
        end
    end

    // root index is meaningless while the input is all zero
    assign cnt_o   = node_idx[0];
    assign empty_o = ~node_vld[0];

endmodule

//--- design/spm_pkg.sv
package spm_pkg;

    // number of requester ports sharing the scratchpad
    localparam int unsigned NUM_PORTS = 4;

    // width of a port index, also the width of the arbiter winner index
    localparam int unsigned PORT_W = $clog2(NUM_PORTS);

    // word address width, the bank holds 2**ADDR_W words
    localparam int unsigned ADDR_W = 6;

    // data word width and the matching byte enable width
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W = DATA_W / 8;

    // one request as presented by a port and held until its grant
    typedef struct packed {
        // set for a write, clear for a read
        logic              we;
        logic [ADDR_W-1:0] addr;
        // byte lane enables, only looked at for writes
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } spm_req_t;

    // response word shared by all ports
    typedef struct packed {
        // read data, don't care for a write
        logic [DATA_W-1:0] rdata;
        // tells the port whether this closes a write or a read
        logic              was_write;
    } spm_rsp_t;

    // controller steps through one access at a time
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } ctrl_state_e;

endpackage
